// File: hw/csr_params.svh
`ifndef CSR_PARAMS_SVH
`define CSR_PARAMS_SVH

// Block base and register offsets
`define CSR_BASE_ADDR      16'h1000
`define CSR_CTRL_OFS       16'h0000
`define CSR_STATUS_OFS     16'h0004
`define CSR_CMD_OFS        16'h0008
`define CSR_EVENT_OFS      16'h000C

// Returned for unmapped reads
`define CSR_DEFAULT_RDATA  32'hDEADBEAF

// CTRL layout and reset
`define CSR_CTRL_RESET     32'h0000_0000
`define CSR_CTRL_WMASK     32'h0000_0FF7
`define CSR_CTRL_EN_BIT    0
`define CSR_CTRL_MODE_LSB  1
`define CSR_CTRL_THR_LSB   4
`define CSR_CTRL_MASK_LSB  8

`define CSR_EVENT_RESET    4'h0

`endif

// File: hw/avalon_pkg.sv
package avalon_pkg;

  // Byte address on both AXI4-Lite and Avalon
  typedef logic [15:0] bus_addr_t;

  typedef logic [31:0] bus_data_t;

  // One enable per byte lane
  typedef logic [3:0] bus_strb_t;

  // Same encoding as AXI resp
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } bus_resp_e;

endpackage

// File: hw/csr_pkg.sv
package csr_pkg;

  // CTRL fields
  typedef logic [1:0] mode_t;
  typedef logic [3:0] threshold_t;

  // Mask, event, set and trigger share one width
  typedef logic [3:0] event_t;

  // Hardware input shown in STATUS
  typedef logic [15:0] status_t;

  // Mapped registers
  typedef enum logic [1:0] {
    REG_CTRL   = 2'd0,
    REG_STATUS = 2'd1,
    REG_CMD    = 2'd2,
    REG_EVENT  = 2'd3
  } reg_sel_e;

endpackage

// File: hw/axil_avalon_adapter.sv
module axil_avalon_adapter (
  input  logic                  clk,
  input  logic                  i_arst_n,
  input  logic                  i_awvalid,
  output logic                  o_awready,
  input  avalon_pkg::bus_addr_t i_awaddr,
  input  logic                  i_wvalid,
  output logic                  o_wready,
  input  avalon_pkg::bus_data_t i_wdata,
  input  avalon_pkg::bus_strb_t i_wstrb,
  output logic                  o_bvalid,
  input  logic                  i_bready,
  output avalon_pkg::bus_resp_e o_bresp,
  input  logic                  i_arvalid,
  output logic                  o_arready,
  input  avalon_pkg::bus_addr_t i_araddr,
  output logic                  o_rvalid,
  input  logic                  i_rready,
  output avalon_pkg::bus_data_t o_rdata,
  output avalon_pkg::bus_resp_e o_rresp,
  output logic                  o_read,
  output logic                  o_write,
  output avalon_pkg::bus_addr_t o_address,
  output avalon_pkg::bus_strb_t o_byteenable,
  output avalon_pkg::bus_data_t o_writedata,
  input  logic                  i_waitrequest,
  input  logic                  i_readdatavalid,
  input  logic                  i_writeresponsevalid,
  input  avalon_pkg::bus_resp_e i_response,
  input  avalon_pkg::bus_data_t i_readdata
);
  import avalon_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_PENDING,
    ST_HOLDING
  } state_e;

  state_e    state;
  state_e    state_next;
  logic      rsp_is_read;
  bus_resp_e rsp_resp;
  bus_data_t rsp_data;
  logic      rsp_taken;
  logic      can_accept;
  logic      accept_rd;
  logic      accept_wr;
  logic      answer;

  assign o_rvalid = (state == ST_HOLDING) && rsp_is_read;
  assign o_bvalid = (state == ST_HOLDING) && !rsp_is_read;
  assign o_rdata  = rsp_data;
  assign o_rresp  = rsp_resp;
  assign o_bresp  = rsp_resp;

  // A new transfer may enter as the buffered response leaves
  assign rsp_taken  = (o_rvalid && i_rready) || (o_bvalid && i_bready);
  assign can_accept = (state == ST_IDLE) || rsp_taken;

  // Reads win over writes
  assign accept_rd = can_accept && i_arvalid;
  assign accept_wr = can_accept && !i_arvalid && i_awvalid && i_wvalid;
  assign o_arready = accept_rd;
  assign o_awready = accept_wr;
  assign o_wready  = accept_wr;

  assign answer = (state == ST_PENDING) && (i_readdatavalid || i_writeresponsevalid);

  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE: begin
        if (accept_rd || accept_wr) begin
          state_next = ST_PENDING;
        end
      end
      ST_PENDING: begin
        if (answer) begin
          state_next = ST_HOLDING;
        end
      end
      ST_HOLDING: begin
        if (accept_rd || accept_wr) begin
          state_next = ST_PENDING;
        end else if (rsp_taken) begin
          state_next = ST_IDLE;
        end
      end
      default: begin
        state_next = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state       <= ST_IDLE;
      o_read      <= 1'b0;
      o_write     <= 1'b0;
      rsp_is_read <= 1'b0;
    end else begin
      state <= state_next;
      // Command stays up until the slave takes it
      if (accept_rd) begin
        o_read <= 1'b1;
      end else if (!i_waitrequest) begin
        o_read <= 1'b0;
      end
      if (accept_wr) begin
        o_write <= 1'b1;
      end else if (!i_waitrequest) begin
        o_write <= 1'b0;
      end
      if (answer) begin
        rsp_is_read <= i_readdatavalid;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept_rd) begin
      o_address    <= i_araddr;
      o_byteenable <= '1;
    end else if (accept_wr) begin
      o_address    <= i_awaddr;
      o_byteenable <= i_wstrb;
      o_writedata  <= i_wdata;
    end
    if (answer) begin
      rsp_resp <= i_response;
      rsp_data <= i_readdata;
    end
  end

  a_one_channel: assert property (
    @(posedge clk) disable iff (!i_arst_n) !(o_arready && o_awready)
  );

endmodule

// File: hw/avalon_csr_slave.sv
`include "csr_params.svh"

module avalon_csr_slave (
  input  logic                  clk,
  input  logic                  i_arst_n,
  input  logic                  i_read,
  input  logic                  i_write,
  input  avalon_pkg::bus_addr_t i_address,
  input  avalon_pkg::bus_strb_t i_byteenable,
  input  avalon_pkg::bus_data_t i_writedata,
  output logic                  o_waitrequest,
  output logic                  o_readdatavalid,
  output logic                  o_writeresponsevalid,
  output avalon_pkg::bus_resp_e o_response,
  output avalon_pkg::bus_data_t o_readdata,
  output logic                  o_wr_en,
  output csr_pkg::reg_sel_e     o_sel,
  output avalon_pkg::bus_data_t o_wdata,
  output avalon_pkg::bus_strb_t o_byteen,
  input  avalon_pkg::bus_data_t i_rdata
);
  import avalon_pkg::*;
  import csr_pkg::*;

  logic      accept;
  bus_addr_t addr_word;
  logic      mapped;

  assign accept    = (i_read || i_write) && !o_waitrequest;
  // Word aligned with the low two bits ignored
  assign addr_word = {i_address[15:2], 2'b00};

  always_comb begin
    mapped = 1'b1;
    o_sel  = REG_CTRL;
    case (addr_word)
      `CSR_BASE_ADDR + `CSR_CTRL_OFS:   o_sel = REG_CTRL;
      `CSR_BASE_ADDR + `CSR_STATUS_OFS: o_sel = REG_STATUS;
      `CSR_BASE_ADDR + `CSR_CMD_OFS:    o_sel = REG_CMD;
      `CSR_BASE_ADDR + `CSR_EVENT_OFS:  o_sel = REG_EVENT;
      default:                          mapped = 1'b0;
    endcase
  end

  assign o_wr_en  = accept && i_write && !i_read && mapped;
  assign o_wdata  = i_writedata;
  assign o_byteen = i_byteenable;

  // Answer one cycle after acceptance and busy meanwhile
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_waitrequest        <= 1'b0;
      o_readdatavalid      <= 1'b0;
      o_writeresponsevalid <= 1'b0;
      o_response           <= RESP_OKAY;
    end else begin
      o_waitrequest        <= accept;
      o_readdatavalid      <= accept && i_read;
      o_writeresponsevalid <= accept && i_write;
      if (accept) begin
        o_response <= mapped ? RESP_OKAY : RESP_SLVERR;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept && i_read) begin
      o_readdata <= mapped ? i_rdata : `CSR_DEFAULT_RDATA;
    end
  end

  a_single_answer: assert property (
    @(posedge clk) disable iff (!i_arst_n) !(o_readdatavalid && o_writeresponsevalid)
  );

endmodule

// File: hw/csr_field_bank.sv
`include "csr_params.svh"

module csr_field_bank (
  input  logic                  clk,
  input  logic                  i_arst_n,
  input  logic                  i_wr_en,
  input  csr_pkg::reg_sel_e     i_sel,
  input  avalon_pkg::bus_data_t i_wdata,
  input  avalon_pkg::bus_strb_t i_byteen,
  output avalon_pkg::bus_data_t o_rdata,
  input  csr_pkg::status_t      i_status,
  input  csr_pkg::event_t       i_event_set,
  output logic                  o_enable,
  output csr_pkg::mode_t        o_mode,
  output csr_pkg::threshold_t   o_threshold,
  output csr_pkg::event_t       o_cmd_trigger,
  output csr_pkg::event_t       o_event,
  output logic                  o_irq
);
  import avalon_pkg::*;
  import csr_pkg::*;

  bus_data_t ctrl_q;
  bus_data_t ctrl_bits;
  event_t    mask;
  event_t    event_q;
  event_t    event_clr;
  event_t    trig_q;
  logic      wr_ctrl;
  logic      wr_cmd;
  logic      wr_event;

  assign wr_ctrl  = i_wr_en && (i_sel == REG_CTRL);
  assign wr_cmd   = i_wr_en && (i_sel == REG_CMD) && i_byteen[0];
  assign wr_event = i_wr_en && (i_sel == REG_EVENT) && i_byteen[0];

  // Writable CTRL bits in enabled bytes
  assign ctrl_bits = {{8{i_byteen[3]}}, {8{i_byteen[2]}}, {8{i_byteen[1]}}, {8{i_byteen[0]}}}
                     & `CSR_CTRL_WMASK;

  // Write 1 to clear
  assign event_clr = wr_event ? i_wdata[3:0] : '0;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      ctrl_q  <= `CSR_CTRL_RESET;
      event_q <= `CSR_EVENT_RESET;
      trig_q  <= '0;
    end else begin
      if (wr_ctrl) begin
        ctrl_q <= (ctrl_q & ~ctrl_bits) | (i_wdata & ctrl_bits);
      end
      // Hardware set beats software clear
      event_q <= (event_q & ~event_clr) | i_event_set;
      trig_q  <= wr_cmd ? i_wdata[3:0] : '0;
    end
  end

  assign o_enable      = ctrl_q[`CSR_CTRL_EN_BIT];
  assign o_mode        = ctrl_q[`CSR_CTRL_MODE_LSB +: $bits(mode_t)];
  assign o_threshold   = ctrl_q[`CSR_CTRL_THR_LSB +: $bits(threshold_t)];
  assign mask          = ctrl_q[`CSR_CTRL_MASK_LSB +: $bits(event_t)];
  assign o_cmd_trigger = trig_q;
  assign o_event       = event_q;
  assign o_irq         = |(event_q & mask);

  always_comb begin
    o_rdata = '0;
    case (i_sel)
      REG_CTRL:   o_rdata = ctrl_q;
      REG_STATUS: o_rdata[15:0] = i_status;
      REG_EVENT:  o_rdata[3:0] = event_q;
      // COMMAND reads back as zero
      default:    o_rdata = '0;
    endcase
  end

  a_trigger_pulse: assert property (
    @(posedge clk) disable iff (!i_arst_n)
    (|o_cmd_trigger) |=> ((o_cmd_trigger & $past(o_cmd_trigger)) == '0)
  );

endmodule

// File: hw/csr_top.sv
module csr_top (
  input  logic                  clk,
  input  logic                  i_arst_n,
  input  logic                  i_awvalid,
  output logic                  o_awready,
  input  avalon_pkg::bus_addr_t i_awaddr,
  input  logic                  i_wvalid,
  output logic                  o_wready,
  input  avalon_pkg::bus_data_t i_wdata,
  input  avalon_pkg::bus_strb_t i_wstrb,
  output logic                  o_bvalid,
  input  logic                  i_bready,
  output avalon_pkg::bus_resp_e o_bresp,
  input  logic                  i_arvalid,
  output logic                  o_arready,
  input  avalon_pkg::bus_addr_t i_araddr,
  output logic                  o_rvalid,
  input  logic                  i_rready,
  output avalon_pkg::bus_data_t o_rdata,
  output avalon_pkg::bus_resp_e o_rresp,
  input  csr_pkg::status_t      i_status,
  input  csr_pkg::event_t       i_event_set,
  output logic                  o_enable,
  output csr_pkg::mode_t        o_mode,
  output csr_pkg::threshold_t   o_threshold,
  output csr_pkg::event_t       o_cmd_trigger,
  output csr_pkg::event_t       o_event,
  output logic                  o_irq
);
  import avalon_pkg::*;
  import csr_pkg::*;

  // Avalon-MM between adapter and slave
  logic      av_read;
  logic      av_write;
  bus_addr_t av_address;
  bus_strb_t av_byteenable;
  bus_data_t av_writedata;
  logic      av_waitrequest;
  logic      av_readdatavalid;
  logic      av_writeresponsevalid;
  bus_resp_e av_response;
  bus_data_t av_readdata;

  // Register access into the bank
  logic      reg_wr_en;
  reg_sel_e  reg_sel;
  bus_data_t reg_wdata;
  bus_strb_t reg_byteen;
  bus_data_t reg_rdata;

  axil_avalon_adapter u_adapter (
    .clk                  (clk),
    .i_arst_n             (i_arst_n),
    .i_awvalid            (i_awvalid),
    .o_awready            (o_awready),
    .i_awaddr             (i_awaddr),
    .i_wvalid             (i_wvalid),
    .o_wready             (o_wready),
    .i_wdata              (i_wdata),
    .i_wstrb              (i_wstrb),
    .o_bvalid             (o_bvalid),
    .i_bready             (i_bready),
    .o_bresp              (o_bresp),
    .i_arvalid            (i_arvalid),
    .o_arready            (o_arready),
    .i_araddr             (i_araddr),
    .o_rvalid             (o_rvalid),
    .i_rready             (i_rready),
    .o_rdata              (o_rdata),
    .o_rresp              (o_rresp),
    .o_read               (av_read),
    .o_write              (av_write),
    .o_address            (av_address),
    .o_byteenable         (av_byteenable),
    .o_writedata          (av_writedata),
    .i_waitrequest        (av_waitrequest),
    .i_readdatavalid      (av_readdatavalid),
    .i_writeresponsevalid (av_writeresponsevalid),
    .i_response           (av_response),
    .i_readdata           (av_readdata)
  );

  avalon_csr_slave u_slave (
    .clk                  (clk),
    .i_arst_n             (i_arst_n),
    .i_read               (av_read),
    .i_write              (av_write),
    .i_address            (av_address),
    .i_byteenable         (av_byteenable),
    .i_writedata          (av_writedata),
    .o_waitrequest        (av_waitrequest),
    .o_readdatavalid      (av_readdatavalid),
    .o_writeresponsevalid (av_writeresponsevalid),
    .o_response           (av_response),
    .o_readdata           (av_readdata),
    .o_wr_en              (reg_wr_en),
    .o_sel                (reg_sel),
    .o_wdata              (reg_wdata),
    .o_byteen             (reg_byteen),
    .i_rdata              (reg_rdata)
  );

  csr_field_bank u_bank (
    .clk           (clk),
    .i_arst_n      (i_arst_n),
    .i_wr_en       (reg_wr_en),
    .i_sel         (reg_sel),
    .i_wdata       (reg_wdata),
    .i_byteen      (reg_byteen),
    .o_rdata       (reg_rdata),
    .i_status      (i_status),
    .i_event_set   (i_event_set),
    .o_enable      (o_enable),
    .o_mode        (o_mode),
    .o_threshold   (o_threshold),
    .o_cmd_trigger (o_cmd_trigger),
    .o_event       (o_event),
    .o_irq         (o_irq)
  );

endmodule

// File: bench/csr_tb.sv
`include "csr_params.svh"

module csr_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import avalon_pkg::*;
  import csr_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int N_CTRL     = 16;
  localparam int N_STATUS   = 4;
  localparam int N_CMD      = 6;
  localparam int N_EVENT    = 6;
  localparam int N_BAD      = 12;
  localparam int N_BP       = 16;
  localparam int NUM_XFERS  = 2 + 2 * N_CTRL + 2 * N_STATUS + 2 * N_CMD + 4 * N_EVENT
                              + N_BAD + N_BP;

  localparam bus_addr_t CTRL_ADDR   = `CSR_BASE_ADDR + `CSR_CTRL_OFS;
  localparam bus_addr_t STATUS_ADDR = `CSR_BASE_ADDR + `CSR_STATUS_OFS;
  localparam bus_addr_t CMD_ADDR    = `CSR_BASE_ADDR + `CSR_CMD_OFS;
  localparam bus_addr_t EVENT_ADDR  = `CSR_BASE_ADDR + `CSR_EVENT_OFS;
  // Enable, mode, threshold, irq mask
  localparam bus_data_t CTRL_FIELDS = 32'h0000_0001 | 32'h0000_0006 | 32'h0000_00F0
                                      | 32'h0000_0F00;

  logic       clk;
  logic       i_arst_n;
  logic       i_awvalid;
  logic       o_awready;
  bus_addr_t  i_awaddr;
  logic       i_wvalid;
  logic       o_wready;
  bus_data_t  i_wdata;
  bus_strb_t  i_wstrb;
  logic       o_bvalid;
  logic       i_bready;
  bus_resp_e  o_bresp;
  logic       i_arvalid;
  logic       o_arready;
  bus_addr_t  i_araddr;
  logic       o_rvalid;
  logic       i_rready;
  bus_data_t  o_rdata;
  bus_resp_e  o_rresp;
  status_t    i_status;
  event_t     i_event_set;
  logic       o_enable;
  mode_t      o_mode;
  threshold_t o_threshold;
  event_t     o_cmd_trigger;
  event_t     o_event;
  logic       o_irq;

  // Shadow registers of the reference model
  bus_data_t exp_ctrl  = '0;
  event_t    exp_event = '0;
  event_t    exp_trig  = '0;

  // Outstanding transfers, oldest first
  bit        rd_q[$];
  bus_data_t data_q[$];
  bus_resp_e resp_q[$];
  int        hs_q[$];

  logic      wr_pending = 1'b0;
  bus_addr_t wr_addr;
  bus_data_t wr_data;
  bus_strb_t wr_strb;
  logic      rsp_seen = 1'b0;
  logic      bp_on = 1'b0;
  int        cycle = 0;
  int        errors = 0;
  int        checks = 0;

  csr_top UUT (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("ERROR at %0t: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  function automatic logic is_mapped(input bus_addr_t addr);
    bus_addr_t word;
    word = {addr[15:2], 2'b00};
    return (word == CTRL_ADDR) || (word == STATUS_ADDR) || (word == CMD_ADDR)
           || (word == EVENT_ADDR);
  endfunction

  function automatic bus_resp_e model_resp(input bus_addr_t addr);
    return is_mapped(addr) ? RESP_OKAY : RESP_SLVERR;
  endfunction

  function automatic bus_data_t model_read(input bus_addr_t addr);
    bus_data_t d;
    d = '0;
    case ({addr[15:2], 2'b00})
      CTRL_ADDR:   d = exp_ctrl;
      STATUS_ADDR: d = {16'h0000, i_status};
      EVENT_ADDR:  d = {28'h0, exp_event};
      CMD_ADDR:    d = '0;
      default:     d = `CSR_DEFAULT_RDATA;
    endcase
    return d;
  endfunction

  function automatic void model_write(input bus_addr_t addr, input bus_data_t data,
                                      input bus_strb_t strb);
    bus_data_t bm;
    bm = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}} & CTRL_FIELDS;
    case ({addr[15:2], 2'b00})
      CTRL_ADDR:  exp_ctrl = (exp_ctrl & ~bm) | (data & bm);
      CMD_ADDR:   exp_trig = strb[0] ? data[3:0] : 4'h0;
      EVENT_ADDR: exp_event = strb[0] ? (exp_event & ~data[3:0]) : exp_event;
      default:    ;
    endcase
  endfunction

  function automatic bus_addr_t random_bad_addr();
    bus_addr_t a;
    do begin
      a = $urandom_range(16'hFFFF) & 16'hFFFC;
    end while (is_mapped(a));
    return a;
  endfunction

  // Compare process, all values taken before the edge updates them
  always @(posedge clk) begin
    if (i_arst_n) begin
      check("o_enable", exp_ctrl[0], o_enable);
      check("o_mode", exp_ctrl[2:1], o_mode);
      check("o_threshold", exp_ctrl[7:4], o_threshold);
      check("o_event", exp_event, o_event);
      check("o_irq", |(exp_event & exp_ctrl[11:8]), o_irq);
      check("o_cmd_trigger", exp_trig, o_cmd_trigger);
      if (o_rvalid || o_bvalid) begin
        if (rd_q.size() == 0) begin
          errors++;
          $display("ERROR at %0t: response seen with no transfer outstanding", $time);
        end else begin
          if (!rsp_seen) begin
            check("response latency", 2, cycle - hs_q[0]);
          end
          rsp_seen = 1'b1;
          check("o_rvalid", rd_q[0], o_rvalid);
          check("o_bvalid", !rd_q[0], o_bvalid);
          if (o_rvalid) begin
            check("o_rdata", data_q[0], o_rdata);
            check("o_rresp", resp_q[0], o_rresp);
          end else begin
            check("o_bresp", resp_q[0], o_bresp);
          end
          if ((o_rvalid && i_rready) || (o_bvalid && i_bready)) begin
            void'(rd_q.pop_front());
            void'(data_q.pop_front());
            void'(resp_q.pop_front());
            void'(hs_q.pop_front());
            rsp_seen = 1'b0;
          end
        end
      end else if (rsp_seen) begin
        errors++;
        $display("ERROR at %0t: response valid dropped before its handshake", $time);
        rsp_seen = 1'b0;
      end
      // Bank acts one edge after the AXI handshake
      exp_trig = '0;
      if (wr_pending) begin
        model_write(wr_addr, wr_data, wr_strb);
        wr_pending = 1'b0;
      end
      exp_event = exp_event | i_event_set;
      if ((i_arvalid && o_arready) || (i_awvalid && o_awready)) begin
        if (rd_q.size() != 0) begin
          errors++;
          $display("ERROR at %0t: transfer accepted while a response was pending", $time);
        end
        rd_q.push_back(i_arvalid);
        hs_q.push_back(cycle + 1);
        if (i_arvalid) begin
          data_q.push_back(model_read(i_araddr));
          resp_q.push_back(model_resp(i_araddr));
        end else begin
          check("o_wready", 1'b1, o_wready);
          data_q.push_back('0);
          resp_q.push_back(model_resp(i_awaddr));
          wr_pending = 1'b1;
          wr_addr    = i_awaddr;
          wr_data    = i_wdata;
          wr_strb    = i_wstrb;
        end
      end
    end
  end

  task automatic read_reg(input bus_addr_t addr);
    @(negedge clk);
    i_arvalid = 1'b1;
    i_araddr  = addr;
    @(posedge clk);
    while (!o_arready) @(posedge clk);
    @(negedge clk);
    i_arvalid = 1'b0;
  endtask

  task automatic write_reg(input bus_addr_t addr, input bus_data_t data,
                           input bus_strb_t strb);
    @(negedge clk);
    i_awvalid = 1'b1;
    i_wvalid  = 1'b1;
    i_awaddr  = addr;
    i_wdata   = data;
    i_wstrb   = strb;
    @(posedge clk);
    while (!o_awready) @(posedge clk);
    @(negedge clk);
    i_awvalid = 1'b0;
    i_wvalid  = 1'b0;
  endtask

  task automatic wait_idle();
    @(negedge clk);
    while (rd_q.size() != 0) @(negedge clk);
  endtask

  task automatic pulse_events(input event_t bits);
    @(negedge clk);
    i_event_set = bits;
    @(negedge clk);
    i_event_set = '0;
  endtask

  // Random low stretches on rready and bready
  task automatic drive_ready();
    int   stretch;
    logic lvl;
    stretch = 0;
    lvl     = 1'b1;
    forever begin
      @(negedge clk);
      if (!bp_on) begin
        lvl = 1'b1;
      end else if (stretch == 0) begin
        lvl     = !lvl;
        stretch = $urandom_range(1, 6);
      end else begin
        stretch--;
      end
      i_rready = lvl;
      i_bready = lvl;
    end
  endtask

  initial begin
    #((NUM_XFERS * 20 + 10) * CLK_PERIOD);
    $display("ERROR at %0t: watchdog expired before the tests finished", $time);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    void'($urandom(32'h5791));
    i_arst_n    = 1'b0;
    i_awvalid   = 1'b0;
    i_awaddr    = '0;
    i_wvalid    = 1'b0;
    i_wdata     = '0;
    i_wstrb     = '0;
    i_bready    = 1'b1;
    i_arvalid   = 1'b0;
    i_araddr    = '0;
    i_rready    = 1'b1;
    i_status    = '0;
    i_event_set = '0;
    fork
      drive_ready();
    join_none
    repeat (10) @(negedge clk);
    i_arst_n = 1'b1;
    @(negedge clk);
    check("o_arready", 1'b0, o_arready);
    check("o_awready", 1'b0, o_awready);
    check("o_wready", 1'b0, o_wready);
    check("o_rvalid", 1'b0, o_rvalid);
    check("o_bvalid", 1'b0, o_bvalid);
    check("o_irq", 1'b0, o_irq);
    read_reg(CTRL_ADDR);
    read_reg(EVENT_ADDR);
    for (int i = 0; i < N_CTRL; i++) begin
      write_reg(CTRL_ADDR, $urandom, $urandom_range(15));
      read_reg(CTRL_ADDR);
    end
    // STATUS must not move while a read is in flight
    for (int i = 0; i < N_STATUS; i++) begin
      wait_idle();
      i_status = $urandom_range(16'hFFFF);
      write_reg(STATUS_ADDR, $urandom, 4'hF);
      read_reg(STATUS_ADDR);
      wait_idle();
    end
    for (int i = 0; i < N_CMD; i++) begin
      write_reg(CMD_ADDR, $urandom, $urandom_range(15));
      read_reg(CMD_ADDR);
    end
    for (int i = 0; i < N_EVENT; i++) begin
      write_reg(CTRL_ADDR, $urandom, 4'hF);
      pulse_events($urandom_range(15));
      read_reg(EVENT_ADDR);
      write_reg(EVENT_ADDR, $urandom, $urandom_range(15));
      read_reg(EVENT_ADDR);
    end
    bp_on = 1'b1;
    for (int i = 0; i < N_BAD; i++) begin
      if ($urandom_range(1) == 1) begin
        read_reg(random_bad_addr());
      end else begin
        write_reg(random_bad_addr(), $urandom, $urandom_range(15));
      end
    end
    for (int i = 0; i < N_BP; i++) begin
      if ($urandom_range(1) == 1) begin
        read_reg(`CSR_BASE_ADDR + {$urandom_range(3), 2'b00});
      end else begin
        write_reg(`CSR_BASE_ADDR + {$urandom_range(3), 2'b00}, $urandom, $urandom_range(15));
      end
    end
    wait_idle();
    bp_on = 1'b0;
    repeat (4) @(negedge clk);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: flist.f
+incdir+hw
hw/avalon_pkg.sv
hw/csr_pkg.sv
hw/axil_avalon_adapter.sv
hw/avalon_csr_slave.sv
hw/csr_field_bank.sv
hw/csr_top.sv
bench/csr_tb.sv

// File: Bender.yml
package:
  name: csr_block

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/avalon_pkg.sv
      - hw/csr_pkg.sv
      - hw/axil_avalon_adapter.sv
      - hw/avalon_csr_slave.sv
      - hw/csr_field_bank.sv
      - hw/csr_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - bench/csr_tb.sv
